//--- rtl/decode_pkg.sv
/*
 * Decode package
 * Widths, operation/operand/size codes and the opcode byte views
 */
package decode_pkg;

   localparam int ADDR_W       = 32;
   localparam int WINDOW_BYTES = 16;
   localparam int WINDOW_W     = WINDOW_BYTES * 8;
   localparam int LEN_W        = 5;

   // Operation classes, ALU group in x86 encoding order
   localparam logic [3:0] OPC_ADD     = 4'd0;
   localparam logic [3:0] OPC_OR      = 4'd1;
   localparam logic [3:0] OPC_ADC     = 4'd2;
   localparam logic [3:0] OPC_SBB     = 4'd3;
   localparam logic [3:0] OPC_AND     = 4'd4;
   localparam logic [3:0] OPC_SUB     = 4'd5;
   localparam logic [3:0] OPC_XOR     = 4'd6;
   localparam logic [3:0] OPC_CMP     = 4'd7;
   localparam logic [3:0] OPC_MOV     = 4'd8;
   localparam logic [3:0] OPC_HLT     = 4'd9;
   localparam logic [3:0] OPC_ILLEGAL = 4'd15;

   localparam logic [1:0] OPND_NONE = 2'd0;
   localparam logic [1:0] OPND_REG  = 2'd1;
   localparam logic [1:0] OPND_MEM  = 2'd2;
   localparam logic [1:0] OPND_IMM  = 2'd3;

   localparam logic [1:0] SIZE_BYTE  = 2'd0;
   localparam logic [1:0] SIZE_WORD  = 2'd1;
   localparam logic [1:0] SIZE_DWORD = 2'd2;

   // Opcode families of the supported subset
   localparam logic [2:0] KIND_ILLEGAL = 3'd0;
   localparam logic [2:0] KIND_ALU_RM  = 3'd1;
   localparam logic [2:0] KIND_ALU_ACC = 3'd2;
   localparam logic [2:0] KIND_GRP     = 3'd3;
   localparam logic [2:0] KIND_MOV_RM  = 3'd4;
   localparam logic [2:0] KIND_MOV_IMM = 3'd5;
   localparam logic [2:0] KIND_HLT     = 3'd6;

   typedef struct packed {
      logic [1:0] top;
      logic [2:0] alu_op;
      logic       imm_form;
      logic       dir;
      logic       wide;
   } alu_view_t;

   // reg_no is the register of B0-BF
   typedef struct packed {
      logic [3:0] top;
      logic       wide;
      logic [2:0] reg_no;
   } movi_view_t;

   typedef union packed {
      alu_view_t  alu_view;
      movi_view_t movi_view;
   } opcode_u;

   function automatic logic [2:0] opc_kind(opcode_u op);
      if (op.alu_view.top == 2'b00 && !op.alu_view.imm_form)
         return KIND_ALU_RM;
      if (op.alu_view.top == 2'b00 && !op.alu_view.dir)
         return KIND_ALU_ACC;
      // 80, 81 and 83; 82 is left out
      if (op.alu_view.top == 2'b10 && op.alu_view.alu_op == 3'd0 && !op.alu_view.imm_form &&
          !(op.alu_view.dir && !op.alu_view.wide))
         return KIND_GRP;
      if (op.alu_view.top == 2'b10 && op.alu_view.alu_op == 3'd1 && !op.alu_view.imm_form)
         return KIND_MOV_RM;
      if (op.movi_view.top == 4'hb)
         return KIND_MOV_IMM;
      if (op == 8'hf4)
         return KIND_HLT;
      return KIND_ILLEGAL;
   endfunction

endpackage

//--- rtl/fields_if.sv
/*
 * Stage-0 field bundle
 * Raw instruction fields held between the extractor and the operand decoder
 */
`timescale 1ns/1ps

interface fields_if import decode_pkg::*; ();

   logic              prefix_66;
   opcode_u           opcode;
   logic              has_modrm;
   logic [7:0]        modrm;
   logic [7:0]        sib;
   logic [31:0]       disp;
   logic [2:0]        disp_bytes;
   logic [31:0]       imm;
   logic [2:0]        imm_bytes;
   logic [LEN_W-1:0]  length;
   logic [ADDR_W-1:0] pc;

   modport src (
      output prefix_66, opcode, has_modrm, modrm, sib, disp, disp_bytes,
             imm, imm_bytes, length, pc
   );

   modport dst (
      input prefix_66, opcode, has_modrm, modrm, sib, disp, disp_bytes,
            imm, imm_bytes, length, pc
   );

endinterface

//--- rtl/decode_control.sv
/*
 * Decode pipeline control
 * Stage valid bits, load enables, fetch acceptance, halt and flush
 */
`timescale 1ns/1ps

module decode_control import decode_pkg::*; (
   input  logic             clk,
   input  logic             reset,
   input  logic             flush,
   input  logic             f_valid,
   input  logic [LEN_W-1:0] f_valid_bytes,
   input  logic [LEN_W-1:0] length,
   input  logic             is_halt,
   input  logic             d_ready,
   output logic             f_ready,
   output logic [LEN_W-1:0] f_bytes_read,
   output logic             s0_load,
   output logic             s1_load,
   output logic             d_valid,
   output logic             halt
);

   logic s0_valid;
   logic s1_valid;
   logic halted;
   logic running;
   logic s0_free;
   logic s1_free;

   // Stage 1 drains when the consumer takes it
   assign s1_free = !s1_valid || d_ready;
   assign s1_load = s0_valid && s1_free;
   assign s0_free = !s0_valid || s1_load;

   // Whole instruction must be inside the shown bytes
   assign f_ready = running && !halted && !flush && s0_free && (f_valid_bytes >= length);
   assign s0_load = f_valid && f_ready;
   assign f_bytes_read = length;

   assign d_valid = s1_valid;
   assign halt    = halted;

   // Holds fetch off for one cycle after reset
   always_ff @(posedge clk) begin
      if (reset)
         running <= 1'b0;
      else
         running <= 1'b1;
   end

   always_ff @(posedge clk) begin
      if (reset || flush) begin
         s0_valid <= 1'b0;
         s1_valid <= 1'b0;
         halted   <= 1'b0;
      end else begin
         if (s0_load)
            s0_valid <= 1'b1;
         else if (s1_load)
            s0_valid <= 1'b0;

         if (s1_load)
            s1_valid <= 1'b1;
         else if (d_ready)
            s1_valid <= 1'b0;

         if (s0_load && is_halt)
            halted <= 1'b1;
      end
   end

endmodule

//--- rtl/field_extractor.sv
/*
 * Decode stage 0
 * Measures the instruction at the window start and registers its raw fields
 */
`timescale 1ns/1ps

module field_extractor import decode_pkg::*; (
   input  logic                clk,
   input  logic [WINDOW_W-1:0] f_window,
   input  logic [ADDR_W-1:0]   f_pc,
   input  logic                s0_load,
   output logic [LEN_W-1:0]    length,
   output logic                is_halt,
   fields_if.src               fields
);

   logic                pfx;
   opcode_u             opc;
   logic [2:0]          kind;
   logic [7:0]          modrm;
   logic [7:0]          sib;
   logic                has_modrm;
   logic                has_sib;
   logic [2:0]          disp_bytes;
   logic [2:0]          imm_bytes;
   logic [2:0]          full_imm;
   logic [3:0]          disp_pos;
   logic [3:0]          imm_pos;
   logic [WINDOW_W-1:0] disp_win;
   logic [WINDOW_W-1:0] imm_win;
   logic [31:0]         disp_raw;
   logic [31:0]         imm_raw;

   function automatic logic [31:0] keep_bytes(logic [31:0] value, logic [2:0] nbytes);
      case (nbytes)
         3'd1:    return {24'b0, value[7:0]};
         3'd2:    return {16'b0, value[15:0]};
         3'd4:    return value;
         default: return 32'b0;
      endcase
   endfunction

   // Single optional operand-size prefix
   assign pfx   = f_window[7:0] == 8'h66;
   assign opc   = pfx ? f_window[15:8] : f_window[7:0];
   assign modrm = pfx ? f_window[23:16] : f_window[15:8];
   assign sib   = pfx ? f_window[31:24] : f_window[23:16];
   assign kind  = opc_kind(opc);

   assign has_modrm = kind == KIND_ALU_RM || kind == KIND_GRP || kind == KIND_MOV_RM;
   assign has_sib   = has_modrm && modrm[7:6] != 2'b11 && modrm[2:0] == 3'd4;
   assign full_imm  = pfx ? 3'd2 : 3'd4;

   always_comb begin
      disp_bytes = 3'd0;
      if (has_modrm) begin
         case (modrm[7:6])
            2'b01: disp_bytes = 3'd1;
            2'b10: disp_bytes = 3'd4;
            2'b00: begin
               // Absolute address, or SIB with no base register
               if (modrm[2:0] == 3'd5 || (has_sib && sib[2:0] == 3'd5))
                  disp_bytes = 3'd4;
            end
            default: disp_bytes = 3'd0;
         endcase
      end
   end

   always_comb begin
      case (kind)
         KIND_ALU_ACC: imm_bytes = opc.alu_view.wide ? full_imm : 3'd1;
         KIND_GRP: begin
            if (opc.alu_view.dir || !opc.alu_view.wide)
               imm_bytes = 3'd1;
            else
               imm_bytes = full_imm;
         end
         KIND_MOV_IMM: imm_bytes = opc.movi_view.wide ? full_imm : 3'd1;
         default:      imm_bytes = 3'd0;
      endcase
   end

   assign disp_pos = {3'b0, pfx} + 4'd1 + {3'b0, has_modrm} + {3'b0, has_sib};
   assign imm_pos  = disp_pos + {1'b0, disp_bytes};
   assign disp_win = f_window >> {disp_pos, 3'b000};
   assign imm_win  = f_window >> {imm_pos, 3'b000};
   assign disp_raw = keep_bytes(disp_win[31:0], disp_bytes);
   assign imm_raw  = keep_bytes(imm_win[31:0], imm_bytes);

   // Illegal bytes fall out as prefix plus one
   assign length  = {1'b0, imm_pos} + {2'b0, imm_bytes};
   assign is_halt = kind == KIND_HLT;

   always_ff @(posedge clk) begin
      if (s0_load) begin
         fields.prefix_66  <= pfx;
         fields.opcode     <= opc;
         fields.has_modrm  <= has_modrm;
         fields.modrm      <= modrm;
         fields.sib        <= has_sib ? sib : 8'h00;
         fields.disp       <= disp_raw;
         fields.disp_bytes <= disp_bytes;
         fields.imm        <= imm_raw;
         fields.imm_bytes  <= imm_bytes;
         fields.length     <= length;
         fields.pc         <= f_pc;
      end
   end

endmodule

//--- rtl/operand_decoder.sv
/*
 * Decode stage 1
 * Turns raw fields into class, size and operands, and holds the output
 */
`timescale 1ns/1ps

module operand_decoder import decode_pkg::*; (
   input  logic              clk,
   fields_if.dst             fields,
   input  logic              s1_load,
   output logic [3:0]        d_op_class,
   output logic [1:0]        d_size,
   output logic [1:0]        d_op0,
   output logic [1:0]        d_op1,
   output logic [2:0]        d_op0_reg,
   output logic [2:0]        d_op1_reg,
   output logic [7:0]        d_modrm,
   output logic [7:0]        d_sib,
   output logic [31:0]       d_disp,
   output logic [31:0]       d_imm,
   output logic [LEN_W-1:0]  d_length,
   output logic [ADDR_W-1:0] d_pc
);

   logic [2:0]  kind;
   logic [1:0]  modrm_mod;
   logic [2:0]  modrm_reg;
   logic [2:0]  modrm_rm;
   logic [1:0]  rm_kind;
   logic        wide;
   logic [1:0]  op_size;
   logic [3:0]  op_class;
   logic [1:0]  size;
   logic [1:0]  op0;
   logic [1:0]  op1;
   logic [2:0]  op0_reg;
   logic [2:0]  op1_reg;
   logic [31:0] disp_ext;
   logic [31:0] imm_ext;

   assign kind      = opc_kind(fields.opcode);
   assign modrm_mod = fields.modrm[7:6];
   assign modrm_reg = fields.modrm[5:3];
   assign modrm_rm  = fields.modrm[2:0];
   assign rm_kind   = (modrm_mod == 2'b11) ? OPND_REG : OPND_MEM;

   assign wide    = (kind == KIND_MOV_IMM) ? fields.opcode.movi_view.wide
                                           : fields.opcode.alu_view.wide;
   assign op_size = !wide ? SIZE_BYTE : (fields.prefix_66 ? SIZE_WORD : SIZE_DWORD);

   always_comb begin
      op_class = OPC_ILLEGAL;
      size     = SIZE_DWORD;
      op0      = OPND_NONE;
      op1      = OPND_NONE;
      op0_reg  = 3'd0;
      op1_reg  = 3'd0;
      case (kind)
         KIND_ALU_RM, KIND_MOV_RM: begin
            op_class = (kind == KIND_MOV_RM) ? OPC_MOV : {1'b0, fields.opcode.alu_view.alu_op};
            size     = op_size;
            // dir set puts the ModRM.reg register first
            if (fields.opcode.alu_view.dir) begin
               op0     = OPND_REG;
               op0_reg = modrm_reg;
               op1     = rm_kind;
               op1_reg = modrm_rm;
            end else begin
               op0     = rm_kind;
               op0_reg = modrm_rm;
               op1     = OPND_REG;
               op1_reg = modrm_reg;
            end
         end
         KIND_ALU_ACC: begin
            op_class = {1'b0, fields.opcode.alu_view.alu_op};
            size     = op_size;
            op0      = OPND_REG;
            op1      = OPND_IMM;
         end
         KIND_GRP: begin
            op_class = {1'b0, modrm_reg};
            size     = op_size;
            op0      = rm_kind;
            op0_reg  = modrm_rm;
            op1      = OPND_IMM;
         end
         KIND_MOV_IMM: begin
            op_class = OPC_MOV;
            size     = op_size;
            op0      = OPND_REG;
            op0_reg  = fields.opcode.movi_view.reg_no;
            op1      = OPND_IMM;
         end
         KIND_HLT: op_class = OPC_HLT;
         default: op_class = OPC_ILLEGAL;
      endcase
   end

   assign disp_ext = (fields.disp_bytes == 3'd1) ? {{24{fields.disp[7]}}, fields.disp[7:0]}
                                                 : fields.disp;

   // Only 83 carries a sign-extended imm8
   assign imm_ext = (kind == KIND_GRP && fields.opcode.alu_view.dir && fields.imm_bytes == 3'd1)
                  ? {{24{fields.imm[7]}}, fields.imm[7:0]} : fields.imm;

   always_ff @(posedge clk) begin
      if (s1_load) begin
         d_op_class <= op_class;
         d_size     <= size;
         d_op0      <= op0;
         d_op1      <= op1;
         d_op0_reg  <= op0_reg;
         d_op1_reg  <= op1_reg;
         d_modrm    <= fields.has_modrm ? fields.modrm : 8'h00;
         d_sib      <= fields.sib;
         d_disp     <= disp_ext;
         d_imm      <= imm_ext;
         d_length   <= fields.length;
         d_pc       <= fields.pc;
      end
   end

endmodule

//--- rtl/decode_top.sv
/*
 * Decode front end top
 * Two-stage decoder for a reduced 32-bit x86 integer subset
 */
`timescale 1ns/1ps

module decode_top import decode_pkg::*; (
   input  logic                clk,
   input  logic                reset,
   input  logic                flush,
   output logic                halt,

   // Fetch side
   input  logic                f_valid,
   output logic                f_ready,
   input  logic [LEN_W-1:0]    f_valid_bytes,
   input  logic [WINDOW_W-1:0] f_window,
   input  logic [ADDR_W-1:0]   f_pc,
   output logic [LEN_W-1:0]    f_bytes_read,

   // Decoded output
   output logic                d_valid,
   input  logic                d_ready,
   output logic [3:0]          d_op_class,
   output logic [1:0]          d_size,
   output logic [1:0]          d_op0,
   output logic [1:0]          d_op1,
   output logic [2:0]          d_op0_reg,
   output logic [2:0]          d_op1_reg,
   output logic [7:0]          d_modrm,
   output logic [7:0]          d_sib,
   output logic [31:0]         d_disp,
   output logic [31:0]         d_imm,
   output logic [LEN_W-1:0]    d_length,
   output logic [ADDR_W-1:0]   d_pc
);

   logic [LEN_W-1:0] length;
   logic             is_halt;
   logic             s0_load;
   logic             s1_load;

   fields_if fields_i ();

   decode_control ctrl (
      .clk           (clk),
      .reset         (reset),
      .flush         (flush),
      .f_valid       (f_valid),
      .f_valid_bytes (f_valid_bytes),
      .length        (length),
      .is_halt       (is_halt),
      .d_ready       (d_ready),
      .f_ready       (f_ready),
      .f_bytes_read  (f_bytes_read),
      .s0_load       (s0_load),
      .s1_load       (s1_load),
      .d_valid       (d_valid),
      .halt          (halt)
   );

   field_extractor stage0 (
      .clk      (clk),
      .f_window (f_window),
      .f_pc     (f_pc),
      .s0_load  (s0_load),
      .length   (length),
      .is_halt  (is_halt),
      .fields   (fields_i.src)
   );

   operand_decoder stage1 (
      .clk        (clk),
      .fields     (fields_i.dst),
      .s1_load    (s1_load),
      .d_op_class (d_op_class),
      .d_size     (d_size),
      .d_op0      (d_op0),
      .d_op1      (d_op1),
      .d_op0_reg  (d_op0_reg),
      .d_op1_reg  (d_op1_reg),
      .d_modrm    (d_modrm),
      .d_sib      (d_sib),
      .d_disp     (d_disp),
      .d_imm      (d_imm),
      .d_length   (d_length),
      .d_pc       (d_pc)
   );

endmodule

//--- verification/clock_gen.sv
/*
 * Testbench clock and reset
 * 8 ns clock, synchronous reset held for the first three cycles
 */
`timescale 1ns/1ps

module clock_gen (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;
   end

endmodule

//--- verification/tb_decode.sv
/*
 * Decode front end testbench
 * Random instruction streams against a reference model, with back-pressure,
 * partial windows, halt and flush
 */
`timescale 1ns/1ps

module tb_decode import decode_pkg::*; ();

   typedef struct packed {
      logic [3:0]        op_class;
      logic [1:0]        size;
      logic [1:0]        op0;
      logic [1:0]        op1;
      logic [2:0]        op0_reg;
      logic [2:0]        op1_reg;
      logic [7:0]        modrm;
      logic [7:0]        sib;
      logic [31:0]       disp;
      logic [31:0]       imm;
      logic [LEN_W-1:0]  length;
      logic [ADDR_W-1:0] pc;
      logic              is_hlt;
   } expect_t;

   logic clk, reset, flush, halt;
   logic f_valid, f_ready, d_valid, d_ready;
   logic [LEN_W-1:0] f_valid_bytes, f_bytes_read, d_length;
   logic [WINDOW_W-1:0] f_window;
   logic [ADDR_W-1:0] f_pc, d_pc;
   logic [3:0] d_op_class;
   logic [1:0] d_size, d_op0, d_op1;
   logic [2:0] d_op0_reg, d_op1_reg;
   logic [7:0] d_modrm, d_sib;
   logic [31:0] d_disp, d_imm;

   logic [7:0] stream[$];
   expect_t fetch_q[$];
   expect_t out_q[$];
   logic [31:0] stream_pc;
   logic [31:0] gen_pc;
   logic model_halt;
   logic hold_valid;
   logic stall;

   clock_gen clk_gen (.clk(clk), .reset(reset));

   decode_top decode_top_i (
      .clk(clk), .reset(reset), .flush(flush), .halt(halt),
      .f_valid(f_valid), .f_ready(f_ready), .f_valid_bytes(f_valid_bytes),
      .f_window(f_window), .f_pc(f_pc), .f_bytes_read(f_bytes_read),
      .d_valid(d_valid), .d_ready(d_ready), .d_op_class(d_op_class), .d_size(d_size),
      .d_op0(d_op0), .d_op1(d_op1), .d_op0_reg(d_op0_reg), .d_op1_reg(d_op1_reg),
      .d_modrm(d_modrm), .d_sib(d_sib), .d_disp(d_disp), .d_imm(d_imm),
      .d_length(d_length), .d_pc(d_pc)
   );

   task automatic stop_run(input string why);
      if (why != "")
         $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
         stop_run("");
      end
   endtask

   function automatic logic [7:0] any_byte();
      logic [31:0] r;
      r = $urandom;
      return r[7:0];
   endfunction

   function automatic int pick_range(input int lo, input int hi);
      return int'($urandom_range(hi, lo));
   endfunction

   // Opcodes of the supported subset
   function automatic bit in_subset(input logic [7:0] b);
      if (b[7:6] == 2'b00 && b[2:0] <= 3'd5)
         return 1'b1;
      if (b == 8'h80 || b == 8'h81 || b == 8'h83)
         return 1'b1;
      if (b >= 8'h88 && b <= 8'h8b)
         return 1'b1;
      if (b[7:4] == 4'hb)
         return 1'b1;
      return b == 8'hf4;
   endfunction

   function automatic logic [7:0] illegal_opcode();
      logic [7:0] b;
      b = any_byte();
      while (in_subset(b) || b == 8'h66)
         b = any_byte();
      return b;
   endfunction

   task automatic push_byte(input logic [7:0] b);
      stream.push_back(b);
      gen_pc = gen_pc + 1;
   endtask

   // Little-endian random field of n bytes
   task automatic push_bytes(input int n, output logic [31:0] value);
      logic [7:0] b;
      value = 32'h0;
      for (int i = 0; i < n; i++) begin
         b = any_byte();
         push_byte(b);
         value = value | ({24'h0, b} << (8 * i));
      end
   endtask

   task automatic gen_instr(input bit make_hlt, input bit keep);
      expect_t e;
      logic pfx, wide, dir, has_modrm, sib5;
      logic [7:0] op, modrm, r8;
      logic [1:0] rmk;
      logic [31:0] raw, start;
      int kind, imm_n, disp_n, full;
      e = '0;
      start = gen_pc;
      pfx = pick_range(0, 3) == 0;
      wide = pick_range(0, 1) == 1;
      dir = pick_range(0, 1) == 1;
      r8 = any_byte();
      modrm = any_byte();
      full = pfx ? 2 : 4;
      has_modrm = 1'b0;
      sib5 = 1'b0;
      imm_n = 0;
      disp_n = 0;
      rmk = OPND_NONE;
      if (make_hlt)
         kind = 6;
      else if (pick_range(0, 19) == 0)
         kind = 0;
      else
         kind = pick_range(1, 5);
      case (kind)
         0: op = illegal_opcode();
         1: begin
            op = {2'b00, r8[2:0], 1'b0, dir, wide};
            has_modrm = 1'b1;
         end
         2: begin
            op = {2'b00, r8[2:0], 2'b10, wide};
            imm_n = wide ? full : 1;
         end
         3: begin
            case (pick_range(0, 2))
               0: op = 8'h80;
               1: op = 8'h81;
               default: op = 8'h83;
            endcase
            has_modrm = 1'b1;
            wide = op[0];
            imm_n = (op == 8'h81) ? full : 1;
         end
         4: begin
            op = {6'b100010, dir, wide};
            has_modrm = 1'b1;
         end
         5: begin
            op = {4'hb, wide, r8[2:0]};
            imm_n = wide ? full : 1;
         end
         default: op = 8'hf4;
      endcase
      if (pfx)
         push_byte(8'h66);
      push_byte(op);
      if (has_modrm) begin
         push_byte(modrm);
         e.modrm = modrm;
         rmk = (modrm[7:6] == 2'b11) ? OPND_REG : OPND_MEM;
         if (modrm[7:6] != 2'b11 && modrm[2:0] == 3'd4) begin
            r8 = any_byte();
            push_byte(r8);
            e.sib = r8;
            sib5 = r8[2:0] == 3'd5;
         end
         if (modrm[7:6] == 2'b01)
            disp_n = 1;
         else if (modrm[7:6] == 2'b10)
            disp_n = 4;
         else if (modrm[7:6] == 2'b00 && (modrm[2:0] == 3'd5 || sib5))
            disp_n = 4;
         push_bytes(disp_n, raw);
         e.disp = (disp_n == 1) ? {{24{raw[7]}}, raw[7:0]} : raw;
      end
      push_bytes(imm_n, raw);
      e.imm = (op == 8'h83) ? {{24{raw[7]}}, raw[7:0]} : raw;

      e.op_class = OPC_ILLEGAL;
      e.size = SIZE_DWORD;
      if (kind >= 1 && kind <= 5)
         e.size = !wide ? SIZE_BYTE : (pfx ? SIZE_WORD : SIZE_DWORD);
      case (kind)
         1, 4: begin
            e.op_class = (kind == 4) ? OPC_MOV : {1'b0, op[5:3]};
            if (dir) begin
               e.op0 = OPND_REG;
               e.op0_reg = modrm[5:3];
               e.op1 = rmk;
               e.op1_reg = modrm[2:0];
            end else begin
               e.op0 = rmk;
               e.op0_reg = modrm[2:0];
               e.op1 = OPND_REG;
               e.op1_reg = modrm[5:3];
            end
         end
         2: begin
            e.op_class = {1'b0, op[5:3]};
            e.op0 = OPND_REG;
            e.op1 = OPND_IMM;
         end
         3: begin
            e.op_class = {1'b0, modrm[5:3]};
            e.op0 = rmk;
            e.op0_reg = modrm[2:0];
            e.op1 = OPND_IMM;
         end
         5: begin
            e.op_class = OPC_MOV;
            e.op0 = OPND_REG;
            e.op0_reg = op[2:0];
            e.op1 = OPND_IMM;
         end
         6: e.op_class = OPC_HLT;
         default: ;
      endcase
      raw = gen_pc - start;
      e.length = raw[LEN_W-1:0];
      e.pc = start;
      e.is_hlt = kind == 6;
      if (keep)
         fetch_q.push_back(e);
   endtask

   // Bytes after an HLT are shown to the DUT but never expected
   task automatic new_stream(input logic [31:0] base, input int count, input bit with_hlt);
      stream.delete();
      fetch_q.delete();
      out_q.delete();
      stream_pc = base;
      gen_pc = base;
      repeat (count) gen_instr(1'b0, 1'b1);
      if (with_hlt) begin
         gen_instr(1'b1, 1'b1);
         repeat (8) gen_instr(1'b0, 1'b0);
      end
   endtask

   task automatic observe();
      expect_t x;
      if (hold_valid && !d_valid)
         stop_run("d_valid dropped before the output was taken");
      if (d_valid) begin
         if (out_q.size() == 0) begin
            stop_run("d_valid high with no instruction in flight");
         end else begin
            x = out_q[0];
            check("d_op_class", 32'(d_op_class), 32'(x.op_class));
            check("d_size", 32'(d_size), 32'(x.size));
            check("d_op0", 32'(d_op0), 32'(x.op0));
            check("d_op1", 32'(d_op1), 32'(x.op1));
            check("d_op0_reg", 32'(d_op0_reg), 32'(x.op0_reg));
            check("d_op1_reg", 32'(d_op1_reg), 32'(x.op1_reg));
            check("d_modrm", 32'(d_modrm), 32'(x.modrm));
            check("d_sib", 32'(d_sib), 32'(x.sib));
            check("d_disp", d_disp, x.disp);
            check("d_imm", d_imm, x.imm);
            check("d_length", 32'(d_length), 32'(x.length));
            check("d_pc", d_pc, x.pc);
            if (d_ready)
               void'(out_q.pop_front());
         end
      end
      hold_valid = d_valid && !d_ready;
      check("halt", 32'(halt), 32'(model_halt));
      if (flush && f_ready)
         stop_run("f_ready high during a flush cycle");
      if (f_valid && f_ready) begin
         if (model_halt) begin
            stop_run("fetch accepted after an HLT");
         end else if (fetch_q.size() == 0) begin
            stop_run("fetch accepted with no instruction left in the stream");
         end else begin
            x = fetch_q.pop_front();
            check("f_bytes_read", 32'(f_bytes_read), 32'(x.length));
            if (f_valid_bytes < x.length) begin
               stop_run("instruction accepted before all its bytes were shown");
            end else begin
               for (int i = 0; i < int'(x.length); i++)
                  void'(stream.pop_front());
               stream_pc = stream_pc + 32'(x.length);
               out_q.push_back(x);
               if (x.is_hlt)
                  model_halt = 1'b1;
               if (out_q.size() > 2)
                  stop_run("more than two instructions in flight");
            end
         end
      end
   endtask

   // Drive after the edge, observe at the falling edge
   task automatic step_cycle(input bit do_flush);
      logic [WINDOW_W-1:0] win;
      int avail, cut;
      @(posedge clk);
      #1;
      avail = (stream.size() > WINDOW_BYTES) ? WINDOW_BYTES : stream.size();
      cut = avail;
      if (!do_flush && pick_range(0, 2) == 0)
         cut = pick_range(0, avail);
      for (int i = 0; i < WINDOW_BYTES; i++)
         win[i*8 +: 8] = (i < cut) ? stream[i] : any_byte();
      f_window = win;
      f_valid_bytes = LEN_W'(cut);
      f_valid = (cut > 0) && (pick_range(0, 7) != 0);
      f_pc = stream_pc;
      d_ready = (stall || do_flush) ? 1'b0 : (pick_range(0, 3) != 0);
      flush = do_flush;
      @(negedge clk);
      observe();
   endtask

   task automatic flush_step();
      step_cycle(1'b1);
      stream.delete();
      fetch_q.delete();
      out_q.delete();
      model_halt = 1'b0;
      hold_valid = 1'b0;
   endtask

   task automatic drain(input int limit);
      int cycles;
      cycles = 0;
      while ((fetch_q.size() != 0 || out_q.size() != 0) && cycles < limit) begin
         step_cycle(1'b0);
         cycles++;
      end
      if (fetch_q.size() != 0 || out_q.size() != 0)
         stop_run("timed out waiting for the instruction stream to drain");
   endtask

   task automatic wait_reset_done();
      int cycles;
      cycles = 0;
      while (reset && cycles < 20) begin
         @(posedge clk);
         @(negedge clk);
         if (reset) begin
            check("f_ready", 32'(f_ready), 32'h0);
            check("d_valid", 32'(d_valid), 32'h0);
            check("halt", 32'(halt), 32'h0);
         end
         cycles++;
      end
      if (reset)
         stop_run("reset did not deassert within 20 cycles");
   endtask

   task automatic fill_stalled(input int limit);
      int cycles;
      cycles = 0;
      while (out_q.size() < 2 && cycles < limit) begin
         step_cycle(1'b0);
         cycles++;
      end
      if (out_q.size() < 2)
         stop_run("timed out waiting for both stages to fill under back-pressure");
   endtask

   initial begin
      flush = 1'b0;
      f_valid = 1'b0;
      f_valid_bytes = LEN_W'(WINDOW_BYTES);
      f_window = '0;
      f_pc = '0;
      d_ready = 1'b0;
      model_halt = 1'b0;
      hold_valid = 1'b0;
      stall = 1'b0;
      void'($urandom(32'ha8c1_79b6));
      wait_reset_done();

      // Long random stream ending in HLT, then fetch must stay off
      new_stream(32'h0000_0000, 300, 1'b1);
      drain(20000);
      repeat (16) step_cycle(1'b0);
      flush_step();

      // Flush with an empty pipe while a full window is shown
      new_stream(32'h0000_2000, 4, 1'b0);
      flush_step();

      // Back-pressure until the pipe is full, then flush the pending work
      new_stream(32'h0000_4000, 40, 1'b0);
      stall = 1'b1;
      fill_stalled(200);
      repeat (6) begin
         step_cycle(1'b0);
         check("f_ready", 32'(f_ready), 32'h0);
      end
      flush_step();
      stall = 1'b0;

      new_stream(32'h0001_0000, 300, 1'b1);
      drain(20000);
      repeat (8) step_cycle(1'b0);

      $display("TEST OK");
      $finish;
   end

endmodule

//--- sources.f
rtl/decode_pkg.sv
rtl/fields_if.sv
rtl/decode_control.sv
rtl/field_extractor.sv
rtl/operand_decoder.sv
rtl/decode_top.sv
verification/clock_gen.sv
verification/tb_decode.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps
TOP      := tb_decode
FILELIST := sources.f
OBJ_DIR  := obj_dir
PASS_MSG := TEST OK

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
